/* fpu_addsub_cases.txt */
# Columns in hex: operand a, operand b, sub, frm, expected result, expected flags
# Flags are NV DZ OF UF NX from bit 4 down to bit 0
3f800000 40000000 0 0 40400000 00
40400000 3f800000 1 0 40000000 00
40400000 bf800000 0 1 40000000 00
3fc00000 40100000 0 3 40700000 00
3f800000 3f800000 1 0 00000000 00
3f800000 3f800000 1 2 80000000 00
80000000 80000000 0 0 80000000 00
3f800000 33800000 0 0 3f800000 01
3f800001 33800000 0 0 3f800002 01
3f800000 33800000 0 4 3f800001 01
3f800000 33000000 0 3 3f800001 01
3f800000 33000000 0 2 3f800000 01
bf800000 b3000000 0 2 bf800001 01
bf800000 b3000000 0 3 bf800000 01
3f800000 33000000 1 0 3f800000 01
3f800000 33000000 1 1 3f7fffff 01
7f7fffff 7f7fffff 0 0 7f800000 05
ff7fffff 7f7fffff 1 0 ff800000 05
00800001 00800000 1 0 00000000 03
80800001 80800000 1 0 80000000 03
7fc00000 3f800000 0 0 7fc00000 00
ffc12345 3f800000 1 0 7fc00000 00
3f800000 7f800001 0 0 7fc00000 10
7f800000 3f800000 1 0 7f800000 00
3f800000 7f800000 1 0 ff800000 00
7f800000 7f800000 1 0 7fc00000 10
3f800000 40000000 0 5 7fc00000 10
3f800000 40000000 1 7 7fc00000 10

/* vlog.f */
fpu_pkg.sv
fp_op_if.sv
fp_align.sv
fp_addsub.sv
fp_special.sv
fp_result_mux.sv
fpu_axil_regs.sv
fpu_addsub_top.sv
fpu_addsub_properties.sv
tb_fpu_addsub.sv

/* tb_fpu_addsub.sv */
/* Testbench for the AXI4-Lite binary32 add/sub unit
   Cases are read from fpu_addsub_cases.txt, so run from the project root
   BREADY and RREADY stall 0 to 3 random cycles on every transfer */
`timescale 1ns/10ps
`default_nettype none

module tb_fpu_addsub import fpu_pkg::*; ();

  localparam int ADDR_W    = 5;
  localparam int STALL_MAX = 4;  // Stall lengths 0..3

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        sub;
    logic [2:0]  frm;
    logic [31:0] res;
    logic [4:0]  flags;
  } case_t;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  case_t cases_q[$];
  int    err_cnt     = 0;
  int    test_cnt    = 0;
  int    fail_cnt    = 0;
  int    cycle_cnt   = 0;
  int    cycle_limit = 200;  // Raised once the cases are known
  int    start_cnt   = 0;
  int    launch_cnt  = 0;

  fpu_addsub_top #(
    .ADDR_W (ADDR_W)
  ) i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wstrb_i   (wstrb),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready)
  );

  always #5 clk = ~clk;  // 10 ns period

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, DUT stopped responding", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // Done must already be low when op_valid pulses
  always @(negedge clk) begin
    if (rst_n && i_dut.i_op_if.op_valid) begin
      launch_cnt++;
      if (i_dut.i_op_if.res_valid) begin
        err_cnt++;
        $display("Done still set in the launch cycle of a new start");
      end
    end
  end

  task automatic wait_drive_slot();
    @(posedge clk);
    #1;  // Inputs change just after the edge
  endtask

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    int stall;
    wait_drive_slot();
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);  // Transfer on the coming edge
    if (wready !== 1'b1) begin
      err_cnt++;
      $display("MISMATCH wready: expected 1, got %01h", wready);
    end
    wait_drive_slot();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    stall   = $urandom % STALL_MAX;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    repeat (stall) begin
      @(negedge clk);
      if (!bvalid) begin
        err_cnt++;
        $display("BVALID dropped before BREADY at address %02h", addr);
      end
    end
    wait_drive_slot();
    bready = 1'b1;
    @(negedge clk);
    if (bresp !== AXI_OKAY) begin
      err_cnt++;
      $display("MISMATCH bresp: expected %01h, got %01h", AXI_OKAY, bresp);
    end
    wait_drive_slot();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    int          stall;
    logic [31:0] held;
    wait_drive_slot();
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    wait_drive_slot();
    arvalid = 1'b0;
    stall   = $urandom % STALL_MAX;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    held = rdata;  // Must not move until RREADY
    repeat (stall) begin
      @(negedge clk);
      if (!rvalid) begin
        err_cnt++;
        $display("RVALID dropped before RREADY at address %02h", addr);
      end
      if (rdata !== held) begin
        err_cnt++;
        $display("MISMATCH rdata: expected %08h, got %08h", held, rdata);
      end
    end
    wait_drive_slot();
    rready = 1'b1;
    @(negedge clk);
    if (rresp !== AXI_OKAY) begin
      err_cnt++;
      $display("MISMATCH rresp: expected %01h, got %01h", AXI_OKAY, rresp);
    end
    data = rdata;
    wait_drive_slot();
    rready = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before) begin
      fail_cnt++;
      $display("Test %0d %s: FAIL", test_cnt, name);
    end else begin
      $display("Test %0d %s: pass", test_cnt, name);
    end
  endtask

  task automatic read_regs_zero();
    logic [31:0] got;
    for (int r = 0; r < 5; r++) begin
      axi_read(ADDR_W'(r * 4), got);
      if (got !== 32'h0) begin
        err_cnt++;
        $display("MISMATCH rdata at %02h: expected %08h, got %08h", r * 4, 32'h0, got);
      end
    end
  endtask

  task automatic run_case(input int idx);
    case_t       c;
    logic [31:0] got;
    logic [31:0] exp_status;
    int          err_before;
    c          = cases_q[idx];
    err_before = err_cnt;
    exp_status = 32'h0000_0100 | {27'b0, c.flags};  // done in bit 8
    axi_write(REG_OPA, c.a);
    axi_write(REG_OPB, c.b);
    axi_write(REG_CTRL, {27'b0, c.frm, c.sub, 1'b1});
    start_cnt++;
    axi_read(REG_STATUS, got);  // B already seen, so done is due
    if (got !== exp_status) begin
      err_cnt++;
      $display("MISMATCH status: expected %08h, got %08h", exp_status, got);
    end
    axi_read(REG_RESULT, got);
    if (got !== c.res) begin
      err_cnt++;
      $display("MISMATCH result: expected %08h, got %08h", c.res, got);
    end
    report_test($sformatf("case %0d (%08h %s %08h, frm %0d)", idx, c.a,
                c.sub ? "-" : "+", c.b, c.frm), err_before);
  endtask

  initial begin
    int          fd;
    int          n;
    int          err_before;
    string       line;
    case_t       c;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_sub;
    logic [31:0] f_frm;
    logic [31:0] f_res;
    logic [31:0] f_flg;
    void'($urandom(32'h34f1_d929));
    clk     = 1'b0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;

    fd = $fopen("fpu_addsub_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open fpu_addsub_cases.txt");
      $display("Finished with errors");
      $finish;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin  // Skip column notes
        n = $sscanf(line, "%h %h %h %h %h %h", f_a, f_b, f_sub, f_frm, f_res, f_flg);
        if (n == 6) begin
          c.a     = f_a;
          c.b     = f_b;
          c.sub   = f_sub[0];
          c.frm   = f_frm[2:0];
          c.res   = f_res;
          c.flags = f_flg[4:0];
          cases_q.push_back(c);
        end
      end
    end
    $fclose(fd);
    if (cases_q.size() == 0) begin
      err_cnt++;
      $display("No cases found in fpu_addsub_cases.txt");
    end
    cycle_limit = 40 * cases_q.size() + 200;

    // Responses stay quiet throughout reset
    err_before = err_cnt;
    repeat (16) begin
      @(negedge clk);
      if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
        err_cnt++;
        $display("BVALID or RVALID not low during reset");
      end
    end
    wait_drive_slot();
    rst_n = 1'b1;
    read_regs_zero();
    report_test("reset state", err_before);

    for (int i = 0; i < cases_q.size(); i++) begin
      run_case(i);
    end

    err_before = err_cnt;
    if (launch_cnt != start_cnt) begin
      err_cnt++;
      $display("Saw %0d launches for %0d start writes", launch_cnt, start_cnt);
    end
    if (i_dut.i_regs.i_props.assert_fail_cnt != 0) begin
      err_cnt++;
      $display("%0d bound assertion failures", i_dut.i_regs.i_props.assert_fail_cnt);
    end
    report_test("launch count and handshake assertions", err_before);

    $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fpu_addsub_properties.sv */
/* Handshake checks bound into every fpu_axil_regs instance
   All checks are off while rst_n_i is low */
`timescale 1ns/10ps
`default_nettype none

module fpu_addsub_properties (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        awready_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i,
  input logic        op_valid_i
);

  int assert_fail_cnt = 0;  // Failed assertions so far

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      assert_fail_cnt++;
      $error("BVALID dropped without BREADY");
    end

  a_rdata_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      assert_fail_cnt++;
      $error("RVALID or RDATA changed without RREADY");
    end

  // Launch is a single-cycle pulse
  a_op_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    op_valid_i |=> !op_valid_i)
    else begin
      assert_fail_cnt++;
      $error("op_valid high for two cycles");
    end

  a_no_aw_in_bresp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i |-> !awready_i)
    else begin
      assert_fail_cnt++;
      $error("AWREADY high while BVALID waits");
    end

endmodule

bind fpu_axil_regs fpu_addsub_properties i_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .awready_i  (awready_o),
  .bvalid_i   (bvalid_o),
  .bready_i   (bready_i),
  .rvalid_i   (rvalid_o),
  .rready_i   (rready_i),
  .rdata_i    (rdata_o),
  .op_valid_i (op_valid_q)
);

`default_nettype wire

/* fpu_addsub_top.sv */
/* Memory-mapped binary32 add/sub unit with an AXI4-Lite slave port
   One operation in flight; poll STATUS.done before reading RESULT
   ADDR_W must be 5 or more */
`timescale 1ns/10ps
`default_nettype none

module fpu_addsub_top import fpu_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [ADDR_W-1:0] s_awaddr_i,
  input  logic              s_awvalid_i,
  output logic              s_awready_o,
  input  logic [31:0]       s_wdata_i,
  input  logic [3:0]        s_wstrb_i,
  input  logic              s_wvalid_i,
  output logic              s_wready_o,
  output logic [1:0]        s_bresp_o,
  output logic              s_bvalid_o,
  input  logic              s_bready_i,
  input  logic [ADDR_W-1:0] s_araddr_i,
  input  logic              s_arvalid_i,
  output logic              s_arready_o,
  output logic [31:0]       s_rdata_o,
  output logic [1:0]        s_rresp_o,
  output logic              s_rvalid_o,
  input  logic              s_rready_i
);

  fp32_t   arith_res;
  fflags_t arith_flags;
  fp32_t   spec_res;
  logic    is_special;
  logic    nv;

  fp_op_if i_op_if ();

  fpu_axil_regs #(
    .ADDR_W (ADDR_W)
  ) i_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awaddr_i  (s_awaddr_i),
    .awvalid_i (s_awvalid_i),
    .awready_o (s_awready_o),
    .wdata_i   (s_wdata_i),
    .wstrb_i   (s_wstrb_i),
    .wvalid_i  (s_wvalid_i),
    .wready_o  (s_wready_o),
    .bresp_o   (s_bresp_o),
    .bvalid_o  (s_bvalid_o),
    .bready_i  (s_bready_i),
    .araddr_i  (s_araddr_i),
    .arvalid_i (s_arvalid_i),
    .arready_o (s_arready_o),
    .rdata_o   (s_rdata_o),
    .rresp_o   (s_rresp_o),
    .rvalid_o  (s_rvalid_o),
    .rready_i  (s_rready_i),
    .op_o      (i_op_if.regs)
  );

  fp_addsub i_addsub (
    .op_i    (i_op_if.dp),
    .res_o   (arith_res),
    .flags_o (arith_flags)
  );

  fp_special i_special (
    .op_i         (i_op_if.dp),
    .is_special_o (is_special),
    .res_o        (spec_res),
    .nv_o         (nv)
  );

  fp_result_mux i_res_mux (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .is_special_i  (is_special),
    .spec_res_i    (spec_res),
    .nv_i          (nv),
    .arith_res_i   (arith_res),
    .arith_flags_i (arith_flags),
    .res_o         (i_op_if.sink)
  );

endmodule

`default_nettype wire

/* fpu_axil_regs.sv */
/* AXI4-Lite slave for the add/sub unit, one outstanding transaction
   Write needs AW and W together and wins over a same-cycle read
   Writes with partial strobes are answered OKAY but ignored
   Unmapped reads return 0; all responses are OKAY */
`timescale 1ns/10ps
`default_nettype none

module fpu_axil_regs import fpu_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [31:0]       wdata_i,
  input  logic [3:0]        wstrb_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic [1:0]        bresp_o,
  output logic              bvalid_o,
  input  logic              bready_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output logic [31:0]       rdata_o,
  output logic [1:0]        rresp_o,
  output logic              rvalid_o,
  input  logic              rready_i,
  fp_op_if.regs             op_o
);

  axil_state_t state_q;
  axil_state_t state_d;
  logic        wr_req;
  logic        wr_go;
  logic        rd_go;
  fp32_t       opa_q;
  fp32_t       opb_q;
  logic        sub_q;
  frm_t        frm_q;
  logic        op_valid_q;
  logic [31:0] rd_mux;
  logic [31:0] rdata_q;

  assign wr_req    = awvalid_i && wvalid_i;
  assign wr_go     = (state_q == AXIL_IDLE) && wr_req;
  assign arready_o = (state_q == AXIL_IDLE) && !wr_req;  // Write has priority
  assign rd_go     = arready_o && arvalid_i;
  assign awready_o = wr_go;  // AW and W accepted together
  assign wready_o  = wr_go;

  always_comb begin
    state_d = state_q;
    case (state_q)
      AXIL_IDLE: begin
        if (wr_go) state_d = AXIL_BRESP;
        else if (rd_go) state_d = AXIL_RDATA;
      end
      AXIL_BRESP: if (bready_i) state_d = AXIL_IDLE;
      AXIL_RDATA: if (rready_i) state_d = AXIL_IDLE;
      default:    state_d = AXIL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= AXIL_IDLE;
    else          state_q <= state_d;
  end

  // Start in CTRL produces a one-cycle launch
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      opa_q      <= '0;
      opb_q      <= '0;
      sub_q      <= 1'b0;
      frm_q      <= FRM_RNE;
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= 1'b0;
      if (wr_go && (wstrb_i == 4'hF)) begin
        case (awaddr_i)
          ADDR_W'(REG_OPA):  opa_q <= wdata_i;
          ADDR_W'(REG_OPB):  opb_q <= wdata_i;
          ADDR_W'(REG_CTRL): begin
            sub_q      <= wdata_i[CTRL_SUB];
            frm_q      <= wdata_i[CTRL_FRM_HI:CTRL_FRM_LO];
            op_valid_q <= wdata_i[CTRL_START];  // New fields seen by the launch
          end
          default: ;  // Read-only or unmapped
        endcase
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (araddr_i)
      ADDR_W'(REG_OPA):    rd_mux = opa_q;
      ADDR_W'(REG_OPB):    rd_mux = opb_q;
      ADDR_W'(REG_CTRL): begin
        rd_mux[CTRL_SUB]                = sub_q;
        rd_mux[CTRL_FRM_HI:CTRL_FRM_LO] = frm_q;
      end
      ADDR_W'(REG_RESULT): rd_mux = op_o.res;
      ADDR_W'(REG_STATUS): begin
        rd_mux[4:0]       = op_o.flags;
        rd_mux[STAT_DONE] = op_o.res_valid;
      end
      default: rd_mux = '0;
    endcase
  end

  // Read data frozen while RVALID waits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)   rdata_q <= '0;
    else if (rd_go) rdata_q <= rd_mux;
  end

  assign bvalid_o = (state_q == AXIL_BRESP);
  assign rvalid_o = (state_q == AXIL_RDATA);
  assign bresp_o  = AXI_OKAY;
  assign rresp_o  = AXI_OKAY;
  assign rdata_o  = rdata_q;

  assign op_o.a        = opa_q;
  assign op_o.b        = opb_q;
  assign op_o.sub      = sub_q;
  assign op_o.frm      = frm_q;
  assign op_o.op_valid = op_valid_q;

endmodule

`default_nettype wire

/* fp_result_mux.sv */
/* Final result select and result register
   Captures one result per op_valid pulse; res_valid drops in the launch cycle
   and returns the cycle after, when the new result is held */
`timescale 1ns/10ps
`default_nettype none

module fp_result_mux import fpu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    is_special_i,
  input  fp32_t   spec_res_i,
  input  logic    nv_i,
  input  fp32_t   arith_res_i,
  input  fflags_t arith_flags_i,
  fp_op_if.sink   res_o
);

  fp32_t   res_q;
  fflags_t flags_q;
  fflags_t spec_flags;
  logic    valid_q;

  always_comb begin
    spec_flags          = '0;
    spec_flags[FLAG_NV] = nv_i;  // Special results raise nothing else
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_q   <= '0;  // RESULT and STATUS read 0 out of reset
      flags_q <= '0;
      valid_q <= 1'b0;
    end else if (res_o.op_valid) begin
      res_q   <= is_special_i ? spec_res_i : arith_res_i;
      flags_q <= is_special_i ? spec_flags : arith_flags_i;
      valid_q <= 1'b1;
    end
  end

  assign res_o.res       = res_q;
  assign res_o.flags     = flags_q;
  assign res_o.res_valid = valid_q & ~res_o.op_valid;  // Old result is stale once launched

endmodule

`default_nettype wire

/* fp_special.sv */
/* NaN, infinity and invalid rounding-mode handling beside the add/sub core
   Every NaN result is the canonical quiet NaN; NV only for sNaN, inf - inf
   or frm 5 to 7. Subnormals are not special, the core reads them as zero */
`timescale 1ns/10ps
`default_nettype none

module fp_special import fpu_pkg::*; (
  fp_op_if.dp     op_i,
  output logic    is_special_o,
  output fp32_t   res_o,
  output logic    nv_o
);

  exp_t a_e;
  exp_t b_e;
  man_t a_m;
  man_t b_m;
  logic b_s;
  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;
  logic snan;
  logic frm_bad;

  assign a_e = op_i.a[30:23];
  assign b_e = op_i.b[30:23];
  assign a_m = op_i.a[22:0];
  assign b_m = op_i.b[22:0];
  assign b_s = op_i.b[31] ^ op_i.sub;  // Effective sign of B

  assign a_nan   = (a_e == 8'hFF) && (a_m != '0);
  assign b_nan   = (b_e == 8'hFF) && (b_m != '0);
  assign a_inf   = (a_e == 8'hFF) && (a_m == '0);
  assign b_inf   = (b_e == 8'hFF) && (b_m == '0);
  assign snan    = (a_nan && !a_m[22]) || (b_nan && !b_m[22]);  // Quiet bit clear
  assign frm_bad = (op_i.frm > FRM_RMM);

  assign is_special_o = frm_bad | a_nan | b_nan | a_inf | b_inf;

  always_comb begin
    res_o = QNAN_C;
    nv_o  = 1'b0;
    if (frm_bad) begin
      nv_o = 1'b1;
    end else if (a_nan || b_nan) begin
      nv_o = snan;
    end else if (a_inf && b_inf && (op_i.a[31] != b_s)) begin
      nv_o = 1'b1;  // inf - inf
    end else if (a_inf) begin
      res_o = op_i.a;
    end else if (b_inf) begin
      res_o = {b_s, 8'hFF, 23'b0};
    end
  end

endmodule

`default_nettype wire

/* fp_addsub.sv */
/* Binary32 add/sub core for finite operands, combinational
   Overflow gives signed infinity in every rounding mode; tiny results flush
   to signed zero with UF and NX. Exact cancellation is +0, -0 under RDN
   NaN, infinity and invalid frm results are replaced by fp_special */
`timescale 1ns/10ps
`default_nettype none

module fp_addsub import fpu_pkg::*; (
  fp_op_if.dp         op_i,
  output fp32_t       res_o,
  output fflags_t     flags_o
);

  logic [35:0]       a_al;
  logic [35:0]       b_al;
  logic              a_s;
  logic              b_s;
  exp_t              e_al;
  ext_man_t          a_m;
  ext_man_t          b_m;
  ext_man_t          big_m;
  ext_man_t          lit_m;
  logic              a_ge;
  logic              eff_sub;
  logic              res_s;
  logic              zero_s;
  logic [27:0]       sum;     // Carry, hidden, fraction, G, R, S
  logic [4:0]        lz;
  logic [27:0]       norm;    // Leading one at bit 27
  logic signed [9:0] exp_n;
  logic signed [9:0] exp_r;
  man_t              m0;
  man_t              man_r;
  logic              lsb;
  logic              grd;
  logic              stk;
  logic              rnd_up;
  logic              inexact;
  logic [23:0]       rnd;

  fp_align i_align (
    .a_i    (op_i.a),
    .b_i    (op_i.b),
    .a_al_o (a_al),
    .b_al_o (b_al)
  );

  assign a_s  = a_al[35];
  assign b_s  = b_al[35] ^ op_i.sub;  // Sub flips B's sign
  assign e_al = a_al[34:27];          // Same exponent on both after alignment
  assign a_m  = a_al[26:0];
  assign b_m  = b_al[26:0];

  // Magnitude compare so subtraction is always big - little
  assign a_ge    = (a_m >= b_m);
  assign big_m   = a_ge ? a_m : b_m;
  assign lit_m   = a_ge ? b_m : a_m;
  assign eff_sub = a_s ^ b_s;
  assign res_s   = a_ge ? a_s : b_s;

  assign sum = eff_sub ? ({1'b0, big_m} - {1'b0, lit_m})
                       : ({1'b0, big_m} + {1'b0, lit_m});

  // Like-signed zeros keep their sign and cancellation follows frm
  assign zero_s = eff_sub ? (op_i.frm == FRM_RDN) : a_s;

  // Leading-one search where the highest set bit wins
  always_comb begin
    lz = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (sum[i]) lz = 5'(27 - i);
    end
  end

  assign norm  = sum << lz;
  assign exp_n = $signed({2'b00, e_al}) + 10'sd1 - $signed({5'b00000, lz});

  assign m0      = norm[26:4];
  assign lsb     = norm[4];
  assign grd     = norm[3];
  assign stk     = |norm[2:0];  // Round and sticky folded together
  assign inexact = grd | stk;

  always_comb begin
    case (op_i.frm)
      FRM_RNE: rnd_up = grd & (stk | lsb);
      FRM_RTZ: rnd_up = 1'b0;
      FRM_RDN: rnd_up = res_s & inexact;
      FRM_RUP: rnd_up = !res_s & inexact;
      FRM_RMM: rnd_up = grd;
      default: rnd_up = 1'b0;  // Invalid modes, result overridden
    endcase
  end

  // Fraction carry-out bumps the exponent, fraction wraps to 0
  assign rnd   = {1'b0, m0} + {23'b0, rnd_up};
  assign exp_r = exp_n + $signed({9'b0, rnd[23]});
  assign man_r = rnd[22:0];

  always_comb begin
    res_o            = {res_s, exp_r[7:0], man_r};
    flags_o          = '0;  // DZ stays 0, no division here
    flags_o[FLAG_NX] = inexact;
    if (sum == '0) begin
      res_o = {zero_s, 31'b0};  // Exact, nothing lost
    end else if (exp_r >= 10'sd255) begin
      res_o            = {res_s, 8'hFF, 23'b0};
      flags_o[FLAG_OF] = 1'b1;
      flags_o[FLAG_NX] = 1'b1;
    end else if (exp_r <= 10'sd0) begin
      res_o            = {res_s, 31'b0};  // Flush, no subnormal output
      flags_o[FLAG_UF] = 1'b1;
      flags_o[FLAG_NX] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* fp_align.sv */
/* Exponent alignment for binary32 add/sub
   Subnormal inputs are read as zero; NaN and infinity are not filtered here
   Outputs are {sign, exponent, ext_man_t}, both at the larger exponent */
`timescale 1ns/10ps
`default_nettype none

module fp_align import fpu_pkg::*; (
  input  fp32_t       a_i,
  input  fp32_t       b_i,
  output logic [35:0] a_al_o,
  output logic [35:0] b_al_o
);

  exp_t        a_e;
  exp_t        b_e;
  exp_t        big_e;
  ext_man_t    a_m;
  ext_man_t    b_m;
  ext_man_t    small_m;
  ext_man_t    small_sh;
  logic [7:0]  diff;
  logic [4:0]  sh_amt;
  logic [53:0] sh_win;  // Upper half kept, lower half collects lost bits
  logic        a_big;

  assign a_e = a_i[30:23];
  assign b_e = b_i[30:23];

  // Hidden bit only for normals, exponent 0 flushes to zero
  assign a_m = (a_e == '0) ? '0 : {1'b1, a_i[22:0], 3'b000};
  assign b_m = (b_e == '0) ? '0 : {1'b1, b_i[22:0], 3'b000};

  assign a_big   = (a_e >= b_e);
  assign big_e   = a_big ? a_e : b_e;
  assign diff    = a_big ? (a_e - b_e) : (b_e - a_e);
  assign sh_amt  = (diff > 8'd27) ? 5'd27 : diff[4:0];  // Beyond 27 all bits end in sticky
  assign small_m = a_big ? b_m : a_m;

  assign sh_win   = {small_m, 27'b0} >> sh_amt;
  assign small_sh = {sh_win[53:28], sh_win[27] | (|sh_win[26:0])};  // OR lost bits into sticky

  assign a_al_o = {a_i[31], big_e, a_big ? a_m : small_sh};
  assign b_al_o = {b_i[31], big_e, a_big ? small_sh : b_m};

endmodule

`default_nettype wire

/* fp_op_if.sv */
/* One add/sub operation and its result between the register block and datapath
   op_valid is a single-cycle pulse; the datapath has no ready and always accepts */
`timescale 1ns/10ps
`default_nettype none

interface fp_op_if import fpu_pkg::*; ();

  fp32_t   a;          // Operand A
  fp32_t   b;          // Operand B
  logic    sub;        // 1 = A - B
  frm_t    frm;
  logic    op_valid;   // Launch pulse
  fp32_t   res;
  fflags_t flags;
  logic    res_valid;  // Result held, drives STATUS.done

  modport regs (output a, b, sub, frm, op_valid, input res, flags, res_valid);
  modport dp   (input a, b, sub, frm);
  modport sink (input op_valid, output res, flags, res_valid);

endinterface

`default_nettype wire

/* fpu_pkg.sv */
/* Shared types and constants for the binary32 add/sub unit
   Flag vectors are ordered NV, DZ, OF, UF, NX with NV in bit 4
   Register map assumes a 32-bit, byte-addressed AXI4-Lite data bus */
`default_nettype none

package fpu_pkg;

  typedef logic [31:0] fp32_t;     // IEEE-754 binary32 value
  typedef logic [7:0]  exp_t;      // Biased exponent
  typedef logic [22:0] man_t;      // Stored fraction, hidden bit excluded
  typedef logic [2:0]  frm_t;      // Static rounding mode
  typedef logic [4:0]  fflags_t;   // Exception flags
  typedef logic [26:0] ext_man_t;  // Hidden bit, 23 fraction bits, guard, round, sticky

  // Rounding modes, RISC-V encoding
  localparam frm_t FRM_RNE = 3'd0;  // Nearest, ties to even
  localparam frm_t FRM_RTZ = 3'd1;  // Towards zero
  localparam frm_t FRM_RDN = 3'd2;  // Towards -inf
  localparam frm_t FRM_RUP = 3'd3;  // Towards +inf
  localparam frm_t FRM_RMM = 3'd4;  // Nearest, ties to max magnitude

  // Bit positions inside fflags_t
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  localparam fp32_t QNAN_C = 32'h7FC0_0000;  // Canonical quiet NaN

  // Register offsets
  localparam logic [4:0] REG_OPA    = 5'h00;
  localparam logic [4:0] REG_OPB    = 5'h04;
  localparam logic [4:0] REG_CTRL   = 5'h08;
  localparam logic [4:0] REG_RESULT = 5'h0C;
  localparam logic [4:0] REG_STATUS = 5'h10;

  // CTRL fields
  localparam int CTRL_START  = 0;  // Self-clearing, reads as 0
  localparam int CTRL_SUB    = 1;
  localparam int CTRL_FRM_LO = 2;
  localparam int CTRL_FRM_HI = 4;

  localparam int STAT_DONE = 8;  // STATUS bits 4:0 hold the flags

  localparam logic [1:0] AXI_OKAY = 2'b00;

  typedef enum logic [1:0] {
    AXIL_IDLE,   // Waiting for an address
    AXIL_BRESP,  // Write response pending
    AXIL_RDATA   // Read data pending
  } axil_state_t;

endpackage

`default_nettype wire
